//--- common/dmr_defs.svh
// Size constants for the DMR lockstep subsystem
// Data path width, mismatch counter width and restore length
`ifndef DMR_DEFS_SVH
`define DMR_DEFS_SVH

// Width of a lane result word and of the register bus data
`define DMR_DATA_W 32

// Width of the saturating mismatch counter
`define DMR_CNT_W 8

// Number of cycles the state restore takes
`define DMR_RECOVERY_CYCLES 4

`endif

//--- common/dmr_pkg.sv
// Shared types for the DMR lockstep subsystem
// Holds the redundancy mode and the register map addresses
`default_nettype none

package dmr_pkg;

  // Redundancy mode of the core pair
  typedef enum logic [1:0] {
    NON_DMR,
    DMR_RUN,
    DMR_RESTORE
  } dmr_mode_e;

  // Register map of the control block
  // REG_ENABLE    bit 0 enables lockstep
  // REG_CONFIG    bit 0 rapid recovery, bit 1 setback,
  //               bit 2 synch request, bit 3 force recovery
  // REG_STATUS    read only, bits 1:0 give the mode
  // REG_MISMATCH  reads the mismatch counter, any write clears it
  typedef enum logic [1:0] {
    REG_ENABLE,
    REG_CONFIG,
    REG_STATUS,
    REG_MISMATCH
  } dmr_reg_addr_e;

  // Bit positions inside REG_CONFIG
  localparam int unsigned CFG_RAPID_BIT   = 0;
  localparam int unsigned CFG_SETBACK_BIT = 1;
  localparam int unsigned CFG_SYNCH_BIT   = 2;
  localparam int unsigned CFG_FORCE_BIT   = 3;

endpackage

`default_nettype wire

//--- hw/dmr_compare.sv
// Lane comparator for the lockstep pair
// Registers a one-cycle error for every valid cycle whose lane words differ
`timescale 1ns/1ns
`default_nettype none
`include "dmr_defs.svh"

module dmr_compare (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`DMR_DATA_W-1:0] lane_a_data_i,
  input  logic [`DMR_DATA_W-1:0] lane_b_data_i,
  input  logic                   lane_valid_i,
  output logic                   dmr_error_o
);

  logic lanes_differ;
  logic mismatch;

  // Compared in every mode, the FSM decides whether it matters
  assign lanes_differ = (lane_a_data_i != lane_b_data_i);
  assign mismatch     = lane_valid_i && lanes_differ;

  // One pipeline stage, so consecutive mismatches give consecutive pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmr_error_o <= 1'b0;
    end else begin
      dmr_error_o <= mismatch;
    end
  end

endmodule

`default_nettype wire

//--- hw/dmr_recovery.sv
// Recovery sequencer standing in for the cores' state restore
// Holds restore for a fixed number of cycles and pulses completion
`timescale 1ns/1ns
`default_nettype none
`include "dmr_defs.svh"

module dmr_recovery (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic recovery_request_i,
  output logic restore_o,
  output logic recovery_finished_o
);

  localparam int unsigned cnt_w = $clog2(`DMR_RECOVERY_CYCLES + 1);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`DMR_RECOVERY_CYCLES - 1);

  typedef enum logic [1:0] {REC_IDLE, REC_RESTORE, REC_DONE} rec_state_e;

  rec_state_e       state_q;
  logic [cnt_w-1:0] cnt_q;

  // Restore starts in the same cycle the request rises
  assign restore_o           = recovery_request_i && (state_q != REC_DONE);
  assign recovery_finished_o = restore_o && (cnt_q == last_cnt);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= REC_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        REC_IDLE, REC_RESTORE: begin
          if (!recovery_request_i) begin
            state_q <= REC_IDLE;
            cnt_q   <= '0;
          end else if (recovery_finished_o) begin
            state_q <= REC_DONE;
            cnt_q   <= '0;
          end else begin
            state_q <= REC_RESTORE;
            cnt_q   <= cnt_q + 1'b1;
          end
        end
        // Rearm only after the request has been dropped
        default: if (!recovery_request_i) state_q <= REC_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dmr_ctrl/dmr_regs.sv
// Register slave of the DMR subsystem on a four-phase req/ack bus
// Holds enable, configuration and the saturating mismatch counter
`timescale 1ns/1ns
`default_nettype none
`include "dmr_defs.svh"

module dmr_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   reg_req_i,
  input  logic                   reg_we_i,
  input  dmr_pkg::dmr_reg_addr_e reg_addr_i,
  input  logic [`DMR_DATA_W-1:0] reg_wdata_i,
  input  dmr_pkg::dmr_mode_e     mode_i,
  input  logic                   mismatch_incr_i,
  input  logic                   force_clear_i,
  output logic [`DMR_DATA_W-1:0] reg_rdata_o,
  output logic                   reg_ack_o,
  output logic                   cfg_enable_o,
  output logic                   cfg_rapid_recovery_o,
  output logic                   cfg_setback_o,
  output logic                   cfg_synch_req_o,
  output logic                   cfg_force_recovery_o
);
  import dmr_pkg::*;

  typedef enum logic {ACK_IDLE, ACK_HIGH} ack_state_e;

  ack_state_e             ack_q;
  logic                   access, wr_en, cnt_clear;
  logic                   enable_q;
  logic [3:0]             config_q;
  logic [`DMR_CNT_W-1:0]  mismatch_cnt_q;
  logic [`DMR_DATA_W-1:0] rdata_d, rdata_q;

  // An access happens once per request, while ack is still low
  assign access    = reg_req_i && (ack_q == ACK_IDLE);
  assign wr_en     = access && reg_we_i;
  assign cnt_clear = wr_en && (reg_addr_i == REG_MISMATCH);

  assign reg_ack_o            = (ack_q == ACK_HIGH);
  assign reg_rdata_o          = rdata_q;
  assign cfg_enable_o         = enable_q;
  assign cfg_rapid_recovery_o = config_q[CFG_RAPID_BIT];
  assign cfg_setback_o        = config_q[CFG_SETBACK_BIT];
  assign cfg_synch_req_o      = config_q[CFG_SYNCH_BIT];
  assign cfg_force_recovery_o = config_q[CFG_FORCE_BIT];

  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      REG_ENABLE:   rdata_d[0] = enable_q;
      REG_CONFIG:   rdata_d[3:0] = config_q;
      REG_STATUS:   rdata_d[1:0] = mode_i;
      REG_MISMATCH: rdata_d[`DMR_CNT_W-1:0] = mismatch_cnt_q;
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q          <= ACK_IDLE;
      enable_q       <= 1'b0;
      config_q       <= '0;
      mismatch_cnt_q <= '0;
      rdata_q        <= '0;
    end else begin
      case (ack_q)
        ACK_IDLE: if (reg_req_i) ack_q <= ACK_HIGH;
        ACK_HIGH: if (!reg_req_i) ack_q <= ACK_IDLE;
        default:  ack_q <= ACK_IDLE;
      endcase

      // Read data is captured at the access and held while ack is high
      if (access) begin
        rdata_q <= rdata_d;
      end

      if (wr_en && reg_addr_i == REG_ENABLE) begin
        enable_q <= reg_wdata_i[0];
      end

      // A software write wins over the FSM consuming the force bit
      if (wr_en && reg_addr_i == REG_CONFIG) begin
        config_q <= reg_wdata_i[3:0];
      end else if (force_clear_i) begin
        config_q[CFG_FORCE_BIT] <= 1'b0;
      end

      if (cnt_clear) begin
        mismatch_cnt_q <= '0;
      end else if (mismatch_incr_i && mismatch_cnt_q != '1) begin
        mismatch_cnt_q <= mismatch_cnt_q + 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(reg_ack_o) |-> $past(reg_req_i));

  // Once saturated the counter only leaves its maximum through a clear
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mismatch_cnt_q == '1 && !cnt_clear) |=> (mismatch_cnt_q == '1));

endmodule

`default_nettype wire

//--- hw/dmr_ctrl/dmr_ctrl.sv
// Lockstep mode FSM for a pair of cores
// Handles synchronised entry, guarded exit, rapid recovery and software resynch
`timescale 1ns/1ns
`default_nettype none

module dmr_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cfg_enable_i,
  input  logic               cfg_rapid_recovery_i,
  input  logic               cfg_setback_i,
  input  logic               cfg_synch_req_i,
  input  logic               cfg_force_recovery_i,
  input  logic               dmr_error_i,
  input  logic               recovery_finished_i,
  input  logic               fetch_en_i,
  input  logic               cores_synch_i,
  input  logic               bus_resp_ok_i,
  output dmr_pkg::dmr_mode_e mode_o,
  output logic               force_clear_o,
  output logic               mismatch_incr_o,
  output logic               recovery_request_o,
  output logic [1:0]         setback_o,
  output logic               sw_synch_req_o,
  output logic               sw_resynch_req_o,
  output logic               grp_in_independent_o,
  output logic               bus_hold_o
);
  import dmr_pkg::*;

  dmr_mode_e mode_d, mode_q;
  logic      synch_req, synch_req_sent_q;
  logic      resynch_req, resynch_req_sent_q;
  logic      cores_synch_q;

  assign mode_o               = mode_q;
  assign grp_in_independent_o = (mode_q == NON_DMR);
  assign recovery_request_o   = (mode_q == DMR_RESTORE);
  assign mismatch_incr_o      = dmr_error_i && (mode_q == DMR_RUN);

  // Requests pulse only on their first cycle
  assign sw_synch_req_o   = synch_req && !synch_req_sent_q;
  assign sw_resynch_req_o = resynch_req && !resynch_req_sent_q;

  always_comb begin
    mode_d        = mode_q;
    setback_o     = 2'b00;
    force_clear_o = 1'b0;
    synch_req     = 1'b0;
    resynch_req   = 1'b0;
    bus_hold_o    = 1'b0;

    case (mode_q)
      DMR_RUN: begin
        if (cfg_rapid_recovery_i) begin
          // Forced or detected error both start a restore
          if (cfg_force_recovery_i || dmr_error_i) begin
            mode_d = DMR_RESTORE;
          end
          force_clear_o = cfg_force_recovery_i;
        end else if (dmr_error_i) begin
          // Without hardware recovery software resynchronises the pair
          resynch_req = 1'b1;
        end
      end
      DMR_RESTORE: begin
        if (recovery_finished_i) begin
          mode_d = DMR_RUN;
        end
      end
      default: begin
        // Enter lockstep once the cores report they are aligned
        if (cfg_enable_i) begin
          synch_req = cfg_synch_req_i;
          if (cores_synch_q) begin
            if (cfg_rapid_recovery_i) begin
              mode_d = DMR_RESTORE;
            end else begin
              mode_d    = DMR_RUN;
              setback_o = 2'b11;
            end
          end
        end
      end
    endcase

    // Before the cores fetch, the mode simply follows the enable bit
    if (!fetch_en_i) begin
      if (cfg_enable_i) begin
        synch_req = 1'b0;
        mode_d    = DMR_RUN;
      end else begin
        mode_d = NON_DMR;
      end
    end

    // Leaving lockstep waits for outstanding bus responses
    if (mode_q == DMR_RUN && !cfg_enable_i) begin
      bus_hold_o = 1'b1;
      if (bus_resp_ok_i) begin
        if (cfg_setback_i) begin
          setback_o = 2'b10;
        end
        mode_d = NON_DMR;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q             <= NON_DMR;
      synch_req_sent_q   <= 1'b0;
      resynch_req_sent_q <= 1'b0;
      cores_synch_q      <= 1'b0;
    end else begin
      mode_q             <= mode_d;
      synch_req_sent_q   <= synch_req;
      resynch_req_sent_q <= resynch_req;
      cores_synch_q      <= cores_synch_i;
    end
  end

  // Completion from the sequencer lasts a single cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    recovery_finished_i |=> !recovery_finished_i);

  // The sequencer reports completion only while a restore is requested
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    recovery_finished_i |-> recovery_request_o);

endmodule

`default_nettype wire

//--- hw/dmr_subsys_top.sv
// Top level of the DMR lockstep control subsystem
// Connects register slave, mode FSM, lane comparator and recovery sequencer
`timescale 1ns/1ns
`default_nettype none
`include "dmr_defs.svh"

module dmr_subsys_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   reg_req_i,
  input  logic                   reg_we_i,
  input  dmr_pkg::dmr_reg_addr_e reg_addr_i,
  input  logic [`DMR_DATA_W-1:0] reg_wdata_i,
  output logic [`DMR_DATA_W-1:0] reg_rdata_o,
  output logic                   reg_ack_o,
  input  logic [`DMR_DATA_W-1:0] lane_a_data_i,
  input  logic [`DMR_DATA_W-1:0] lane_b_data_i,
  input  logic                   lane_valid_i,
  input  logic                   fetch_en_i,
  input  logic                   cores_synch_i,
  input  logic                   bus_resp_ok_i,
  output logic [1:0]             setback_o,
  output logic                   sw_synch_req_o,
  output logic                   sw_resynch_req_o,
  output logic                   grp_in_independent_o,
  output logic                   recovery_active_o,
  output logic                   restore_o,
  output logic                   bus_hold_o
);
  import dmr_pkg::*;

  dmr_mode_e mode;
  logic      cfg_enable, cfg_rapid_recovery, cfg_setback;
  logic      cfg_synch_req, cfg_force_recovery;
  logic      force_clear, mismatch_incr, dmr_error;
  logic      recovery_request, recovery_finished;

  assign recovery_active_o = recovery_request;

  dmr_regs i_regs (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .reg_req_i            (reg_req_i),
    .reg_we_i             (reg_we_i),
    .reg_addr_i           (reg_addr_i),
    .reg_wdata_i          (reg_wdata_i),
    .mode_i               (mode),
    .mismatch_incr_i      (mismatch_incr),
    .force_clear_i        (force_clear),
    .reg_rdata_o          (reg_rdata_o),
    .reg_ack_o            (reg_ack_o),
    .cfg_enable_o         (cfg_enable),
    .cfg_rapid_recovery_o (cfg_rapid_recovery),
    .cfg_setback_o        (cfg_setback),
    .cfg_synch_req_o      (cfg_synch_req),
    .cfg_force_recovery_o (cfg_force_recovery)
  );

  dmr_ctrl i_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cfg_enable_i         (cfg_enable),
    .cfg_rapid_recovery_i (cfg_rapid_recovery),
    .cfg_setback_i        (cfg_setback),
    .cfg_synch_req_i      (cfg_synch_req),
    .cfg_force_recovery_i (cfg_force_recovery),
    .dmr_error_i          (dmr_error),
    .recovery_finished_i  (recovery_finished),
    .fetch_en_i           (fetch_en_i),
    .cores_synch_i        (cores_synch_i),
    .bus_resp_ok_i        (bus_resp_ok_i),
    .mode_o               (mode),
    .force_clear_o        (force_clear),
    .mismatch_incr_o      (mismatch_incr),
    .recovery_request_o   (recovery_request),
    .setback_o            (setback_o),
    .sw_synch_req_o       (sw_synch_req_o),
    .sw_resynch_req_o     (sw_resynch_req_o),
    .grp_in_independent_o (grp_in_independent_o),
    .bus_hold_o           (bus_hold_o)
  );

  dmr_compare i_compare (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lane_a_data_i (lane_a_data_i),
    .lane_b_data_i (lane_b_data_i),
    .lane_valid_i  (lane_valid_i),
    .dmr_error_o   (dmr_error)
  );

  dmr_recovery i_recovery (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .recovery_request_i  (recovery_request),
    .restore_o           (restore_o),
    .recovery_finished_o (recovery_finished)
  );

endmodule

`default_nettype wire

//--- verif/tb_dmr_subsys.sv
// Self-checking testbench for the DMR lockstep subsystem
// LFSR lane traffic and register accesses checked against a small mode and counter model
`timescale 1ns/1ns
`default_nettype none
`include "dmr_defs.svh"

module tb_dmr_subsys;
  import dmr_pkg::*;

  localparam int unsigned TIMEOUT   = 50;
  localparam int unsigned CNT_MAX   = (1 << `DMR_CNT_W) - 1;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   reg_req_i;
  logic                   reg_we_i;
  dmr_reg_addr_e          reg_addr_i;
  logic [`DMR_DATA_W-1:0] reg_wdata_i;
  logic [`DMR_DATA_W-1:0] reg_rdata_o;
  logic                   reg_ack_o;
  logic [`DMR_DATA_W-1:0] lane_a_data_i;
  logic [`DMR_DATA_W-1:0] lane_b_data_i;
  logic                   lane_valid_i;
  logic                   fetch_en_i;
  logic                   cores_synch_i;
  logic                   bus_resp_ok_i;
  logic [1:0]             setback_o;
  logic                   sw_synch_req_o;
  logic                   sw_resynch_req_o;
  logic                   grp_in_independent_o;
  logic                   recovery_active_o;
  logic                   restore_o;
  logic                   bus_hold_o;

  logic [31:0] lfsr;
  dmr_mode_e   model_mode;
  int unsigned model_cnt;
  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned test_err_start;
  string       cur_test;

  // Pulse and level counts, taken on the falling edge where outputs are settled
  int unsigned resynch_seen = 0;
  int unsigned synch_seen = 0;
  int unsigned restore_seen = 0;
  int unsigned active_seen = 0;
  int unsigned setback_seen = 0;
  logic [1:0]  last_setback = 2'b00;

  dmr_subsys_top dut (.*);

  always #50 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (sw_resynch_req_o) resynch_seen++;
      if (sw_synch_req_o) synch_seen++;
      if (restore_o) restore_seen++;
      if (recovery_active_o) active_seen++;
      if (setback_o != 2'b00) begin
        setback_seen++;
        last_setback = setback_o;
      end
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int unsigned n, output logic [31:0] value);
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic check_word(input string what, input logic [`DMR_DATA_W-1:0] exp,
                            input logic [`DMR_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %0h actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %b actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_mode(input string what, input dmr_mode_e exp, input dmr_mode_e act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %s actual %s (%0d)", cur_test, what, exp.name(),
               act.name(), act);
      errors++;
    end
  endtask

  // Four-phase transfer: raise req, wait for ack, drop req, wait for ack to fall
  task automatic bus_access(input logic we, input dmr_reg_addr_e addr,
                            input logic [`DMR_DATA_W-1:0] wdata,
                            output logic [`DMR_DATA_W-1:0] rdata);
    int unsigned n;
    @(posedge clk_i);
    reg_we_i    <= we;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    reg_req_i   <= 1'b1;
    for (n = 1; n <= TIMEOUT; n++) begin
      @(negedge clk_i);
      if (reg_ack_o) break;
    end
    if (n > TIMEOUT) begin
      $display("%s: no ack for the %s access", cur_test, addr.name());
      errors++;
    end
    rdata = reg_rdata_o;
    @(posedge clk_i);
    reg_req_i <= 1'b0;
    for (n = 1; n <= TIMEOUT; n++) begin
      @(negedge clk_i);
      if (!reg_ack_o) break;
    end
    if (n > TIMEOUT) begin
      $display("%s: ack stayed high after req was released", cur_test);
      errors++;
    end
  endtask

  task automatic reg_write(input dmr_reg_addr_e addr, input logic [`DMR_DATA_W-1:0] wdata);
    logic [`DMR_DATA_W-1:0] unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_read(input dmr_reg_addr_e addr, output logic [`DMR_DATA_W-1:0] rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  task automatic wait_active(input logic level, output int unsigned cycles);
    for (cycles = 1; cycles <= TIMEOUT; cycles++) begin
      @(negedge clk_i);
      if (recovery_active_o === level) break;
    end
    if (cycles > TIMEOUT) begin
      $display("%s: recovery_active_o never went to %b", cur_test, level);
      errors++;
    end
  endtask

  task automatic wait_independent(input logic level, output int unsigned cycles);
    for (cycles = 1; cycles <= TIMEOUT; cycles++) begin
      @(negedge clk_i);
      if (grp_in_independent_o === level) break;
    end
    if (cycles > TIMEOUT) begin
      $display("%s: grp_in_independent_o never went to %b", cur_test, level);
      errors++;
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(negedge clk_i);
  endtask

  // A differing lane B has one random bit flipped
  task automatic drive_lanes(input logic valid, input logic differ);
    logic [31:0] word;
    logic [31:0] idx;
    rand_bits(32, word);
    idx = '0;
    if (differ) rand_bits(5, idx);
    @(posedge clk_i);
    lane_a_data_i <= word;
    lane_b_data_i <= differ ? (word ^ (32'h1 << idx[4:0])) : word;
    lane_valid_i  <= valid;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == test_err_start) begin
      $display("test %s: PASS", cur_test);
    end else begin
      $display("test %s: FAIL (%0d errors)", cur_test, errors - test_err_start);
      tests_failed++;
    end
  endtask

  task automatic check_status(input string what);
    logic [`DMR_DATA_W-1:0] rd;
    reg_read(REG_STATUS, rd);
    check_mode(what, model_mode, dmr_mode_e'(rd[1:0]));
    check_word({what, " word"}, {{(`DMR_DATA_W-2){1'b0}}, model_mode}, rd);
  endtask

  initial begin
    logic [`DMR_DATA_W-1:0] rd;
    logic [31:0]            r;
    logic                   valid;
    logic                   differ;
    logic                   prev_mis;
    int unsigned            exp_runs;
    int unsigned            base_a;
    int unsigned            base_rest;
    int unsigned            base_sb;
    int unsigned            base_sy;
    int unsigned            base_r;
    int unsigned            lat;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    reg_req_i     = 1'b0;
    reg_we_i      = 1'b0;
    reg_addr_i    = REG_ENABLE;
    reg_wdata_i   = '0;
    lane_a_data_i = '0;
    lane_b_data_i = '0;
    lane_valid_i  = 1'b0;
    fetch_en_i    = 1'b0;
    cores_synch_i = 1'b0;
    bus_resp_ok_i = 1'b0;
    lfsr          = 32'hdc53;
    model_mode    = NON_DMR;
    model_cnt     = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    idle_cycles(1);

    start_test("reset_state");
    check_status("status after reset");
    reg_read(REG_MISMATCH, rd);
    check_word("mismatch count", 32'h0, rd);
    check_bit("independent", 1'b1, grp_in_independent_o);
    rand_bits(32, r);
    reg_write(REG_CONFIG, r);
    reg_read(REG_CONFIG, rd);
    check_word("config readback", r & 32'hf, rd);
    reg_write(REG_CONFIG, 32'h0);
    end_test();

    start_test("enable_without_fetch");
    reg_write(REG_ENABLE, 32'h1);
    model_mode = DMR_RUN;
    check_status("status after enable");
    check_bit("independent", 1'b0, grp_in_independent_o);
    end_test();

    start_test("mismatch_count");
    @(posedge clk_i);
    fetch_en_i <= 1'b1;
    base_r   = resynch_seen;
    exp_runs = 0;
    prev_mis = 1'b0;
    for (int i = 0; i < 200; i++) begin
      rand_bits(3, r);
      valid  = (r[2:1] != 2'b00);
      differ = r[0];
      if (valid && differ) begin
        if (model_cnt < CNT_MAX) model_cnt++;
        if (!prev_mis) exp_runs++;
      end
      prev_mis = valid && differ;
      drive_lanes(valid, differ);
    end
    @(posedge clk_i);
    lane_valid_i <= 1'b0;
    idle_cycles(3);
    reg_read(REG_MISMATCH, rd);
    check_word("mismatch count", model_cnt, rd);
    check_word("resynch pulses", exp_runs, resynch_seen - base_r);
    reg_write(REG_MISMATCH, 32'h0);
    model_cnt = 0;
    reg_read(REG_MISMATCH, rd);
    check_word("count after clear", 32'h0, rd);
    check_status("status after traffic");
    end_test();

    start_test("rapid_recovery");
    reg_write(REG_CONFIG, 32'h1);
    base_a    = active_seen;
    base_rest = restore_seen;
    drive_lanes(1'b1, 1'b1);
    model_cnt++;
    @(posedge clk_i);
    lane_valid_i <= 1'b0;
    wait_active(1'b1, lat);
    check_word("recovery latency", 32'd2, lat);
    wait_active(1'b0, lat);
    check_word("active cycles", `DMR_RECOVERY_CYCLES, active_seen - base_a);
    check_word("restore cycles", `DMR_RECOVERY_CYCLES, restore_seen - base_rest);
    check_status("status after recovery");
    reg_read(REG_MISMATCH, rd);
    check_word("mismatch count", model_cnt, rd);
    // Forced recovery, no lane error involved
    base_a    = active_seen;
    base_rest = restore_seen;
    reg_write(REG_CONFIG, 32'h9);
    wait_active(1'b1, lat);
    wait_active(1'b0, lat);
    check_word("forced active cycles", `DMR_RECOVERY_CYCLES, active_seen - base_a);
    check_word("forced restore cycles", `DMR_RECOVERY_CYCLES, restore_seen - base_rest);
    reg_read(REG_CONFIG, rd);
    check_word("config after force", 32'h1, rd);
    check_status("status after forced recovery");
    end_test();

    start_test("guarded_exit");
    reg_write(REG_CONFIG, 32'h2);
    reg_write(REG_ENABLE, 32'h0);
    idle_cycles(4);
    check_bit("bus hold", 1'b1, bus_hold_o);
    check_status("status while held");
    base_sb = setback_seen;
    @(posedge clk_i);
    bus_resp_ok_i <= 1'b1;
    wait_independent(1'b1, lat);
    model_mode = NON_DMR;
    check_word("setback pulses", 32'd1, setback_seen - base_sb);
    check_word("setback value", {{(`DMR_DATA_W-2){1'b0}}, 2'b10},
               {{(`DMR_DATA_W-2){1'b0}}, last_setback});
    check_bit("bus hold released", 1'b0, bus_hold_o);
    check_status("status after exit");
    @(posedge clk_i);
    bus_resp_ok_i <= 1'b0;
    end_test();

    start_test("synch_entry");
    reg_write(REG_CONFIG, 32'h4);
    base_sy = synch_seen;
    reg_write(REG_ENABLE, 32'h1);
    idle_cycles(4);
    check_word("synch pulses", 32'd1, synch_seen - base_sy);
    check_bit("independent before synch", 1'b1, grp_in_independent_o);
    base_sb = setback_seen;
    @(posedge clk_i);
    cores_synch_i <= 1'b1;
    wait_independent(1'b0, lat);
    model_mode = DMR_RUN;
    check_word("setback pulses", 32'd1, setback_seen - base_sb);
    check_word("setback value", {{(`DMR_DATA_W-2){1'b0}}, 2'b11},
               {{(`DMR_DATA_W-2){1'b0}}, last_setback});
    check_word("synch pulses after entry", 32'd1, synch_seen - base_sy);
    check_status("status after entry");
    end_test();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dmr_subsys_top.f
+incdir+common
common/dmr_pkg.sv
hw/dmr_compare.sv
hw/dmr_recovery.sv
hw/dmr_ctrl/dmr_regs.sv
hw/dmr_ctrl/dmr_ctrl.sv
hw/dmr_subsys_top.sv
verif/tb_dmr_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DMR subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f dmr_subsys_top.f --top-module tb_dmr_subsys -o sim_tb_dmr_subsys

out=$(./obj_dir/sim_tb_dmr_subsys)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  exit 0
else
  exit 1
fi
